// File: logic/strm_pkg.sv
// ##############################
// Streamer package
// Widths, depths and enums shared by the
// load and store streamers and the scratchpad
// ##############################
`default_nettype none

package strm_pkg;

  localparam int ADDR_W    = 10;               // byte address, 1 KiB
  localparam int STRM_DW   = 32;               // stream beat width
  localparam int MEM_DW    = STRM_DW + 32;     // two words for realignment
  localparam int MEM_WORDS = 256;              // 32-bit words
  localparam int WORD_AW   = $clog2(MEM_WORDS);
  localparam int CNT_W     = 8;                // beat count width
  localparam int OFS_DEPTH = 4;                // >= outstanding reads (2)
  localparam int OFS_AW    = $clog2(OFS_DEPTH);

  typedef enum logic [1:0] {
    STRM_IDLE,
    STRM_WORKING,   // addresses still going out
    STRM_DRAIN      // waiting for the tail of the job
  } strm_state_e;

  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_op_e;

endpackage

`default_nettype wire

// File: logic/strm_addr_gen.sv
// ##############################
// Strided address generator
// Holds each byte address until taken,
// flags the last one of the job
// ##############################
`default_nettype none

module strm_addr_gen (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        start_i,
  input  logic [strm_pkg::ADDR_W-1:0] base_i,
  input  logic [strm_pkg::ADDR_W-1:0] stride_i,
  input  logic [strm_pkg::CNT_W-1:0]  count_i,
  input  logic                        addr_ready_i,
  output logic                        addr_valid_o,
  output logic [strm_pkg::ADDR_W-1:0] addr_o,
  output logic                        last_o
);

  logic [strm_pkg::ADDR_W-1:0] addr_q;
  logic [strm_pkg::ADDR_W-1:0] stride_q;
  logic [strm_pkg::CNT_W-1:0]  rem_q;    // addresses left incl. current
  logic                        valid_q;
  logic                        take;

  assign take         = valid_q & addr_ready_i;
  assign addr_valid_o = valid_q;
  assign addr_o       = addr_q;
  assign last_o       = valid_q & (rem_q == strm_pkg::CNT_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      rem_q   <= '0;
    end else if (start_i) begin
      valid_q <= (count_i != '0);     // empty job stays quiet
      rem_q   <= count_i;
    end else if (take) begin
      valid_q <= ~last_o;             // quiet after final take
      rem_q   <= rem_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= base_i;
      stride_q <= stride_i;
    end else if (take) begin
      addr_q <= addr_q + stride_q;    // wraps within the byte space
    end
  end

  a_take_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    addr_ready_i |-> addr_valid_o);

endmodule

`default_nettype wire

// File: logic/strm_source.sv
// ##############################
// Load streamer
// Strided reads from the scratchpad,
// realigned into a 32-bit stream
// ##############################
`default_nettype none

module strm_source (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         start_i,
  input  logic [strm_pkg::ADDR_W-1:0]  base_i,
  input  logic [strm_pkg::ADDR_W-1:0]  stride_i,
  input  logic [strm_pkg::CNT_W-1:0]   count_i,
  output logic                         ready_o,
  output logic                         done_o,
  output logic                         req_o,
  output strm_pkg::mem_op_e            op_o,
  output logic [strm_pkg::ADDR_W-1:0]  addr_o,
  input  logic                         gnt_i,
  input  logic                         r_valid_i,
  input  logic [strm_pkg::MEM_DW-1:0]  r_data_i,
  output logic                         src_valid_o,
  output logic [strm_pkg::STRM_DW-1:0] src_data_o,
  input  logic                         src_ready_i
);

  strm_pkg::strm_state_e cs, ns;

  logic                        start_go;
  logic                        ag_valid;
  logic                        ag_take;
  logic                        ag_last;
  logic [strm_pkg::ADDR_W-1:0] ag_addr;
  logic [strm_pkg::CNT_W-1:0]  count_q;
  logic [strm_pkg::CNT_W-1:0]  beat_q;
  logic                        beat_xfer;

  logic [1:0]                  ofs_mem [strm_pkg::OFS_DEPTH];
  logic [strm_pkg::OFS_AW-1:0] ofs_wptr, ofs_rptr;
  logic [strm_pkg::OFS_AW:0]   ofs_cnt;
  logic                        ofs_push, ofs_pop;

  logic                        skid_valid_q;
  logic [strm_pkg::MEM_DW-1:0] skid_q;
  logic [strm_pkg::MEM_DW-1:0] raw_data;
  logic [strm_pkg::MEM_DW-1:0] aligned;

  assign ready_o  = (cs == strm_pkg::STRM_IDLE);
  assign start_go = start_i & ready_o;

  strm_addr_gen i_addr_gen (
    .clk_i        ( clk_i    ),
    .rst_ni       ( rst_ni   ),
    .start_i      ( start_go ),
    .base_i       ( base_i   ),
    .stride_i     ( stride_i ),
    .count_i      ( count_i  ),
    .addr_ready_i ( ag_take  ),
    .addr_valid_o ( ag_valid ),
    .addr_o       ( ag_addr  ),
    .last_o       ( ag_last  )
  );

  assign req_o   = (cs == strm_pkg::STRM_WORKING) & ag_valid & src_ready_i;  // stop on backpressure
  assign op_o    = strm_pkg::MEM_READ;
  assign addr_o  = {ag_addr[strm_pkg::ADDR_W-1:2], 2'b00};                   // word aligned
  assign ag_take = req_o & gnt_i;

  // byte offsets of reads in flight or parked in skid
  assign ofs_push = ag_take;
  assign ofs_pop  = beat_xfer;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ofs_wptr <= '0;
      ofs_rptr <= '0;
      ofs_cnt  <= '0;
    end else begin
      if (ofs_push) ofs_wptr <= ofs_wptr + 1'b1;
      if (ofs_pop)  ofs_rptr <= ofs_rptr + 1'b1;
      ofs_cnt <= ofs_cnt + ofs_push - ofs_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ofs_push) ofs_mem[ofs_wptr] <= ag_addr[1:0];
  end

  // skid holds a word that arrived while stream was stalled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)                       skid_valid_q <= 1'b0;
    else if (r_valid_i & ~src_ready_i) skid_valid_q <= 1'b1;
    else if (src_ready_i)              skid_valid_q <= 1'b0;  // drained
  end

  always_ff @(posedge clk_i) begin
    if (r_valid_i) skid_q <= r_data_i;
  end

  assign raw_data    = skid_valid_q ? skid_q : r_data_i;         // parked word first
  assign aligned     = raw_data >> {ofs_mem[ofs_rptr], 3'b000};  // drop leading bytes
  assign src_data_o  = aligned[strm_pkg::STRM_DW-1:0];
  assign src_valid_o = r_valid_i | skid_valid_q;
  assign beat_xfer   = src_valid_o & src_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)        beat_q <= '0;
    else if (start_go)  beat_q <= '0;
    else if (beat_xfer) beat_q <= beat_q + 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (start_go) count_q <= count_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) cs <= strm_pkg::STRM_IDLE;
    else         cs <= ns;
  end

  always_comb begin
    ns     = cs;
    done_o = 1'b0;
    case (cs)
      strm_pkg::STRM_IDLE: begin
        if (start_i) ns = strm_pkg::STRM_WORKING;
      end
      strm_pkg::STRM_WORKING: begin
        if (!ag_valid || (ag_take && ag_last)) ns = strm_pkg::STRM_DRAIN;  // all reads issued
      end
      strm_pkg::STRM_DRAIN: begin
        if (beat_q == count_q) begin  // every beat delivered
          ns     = strm_pkg::STRM_IDLE;
          done_o = 1'b1;
        end
      end
      default: ns = strm_pkg::STRM_IDLE;
    endcase
  end

  a_ofs_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ofs_push |-> (int'(ofs_cnt) < strm_pkg::OFS_DEPTH));

  a_rvalid_has_ofs : assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_i |-> (ofs_cnt != '0));

endmodule

`default_nettype wire

// File: logic/strm_sink.sv
// ##############################
// Store streamer
// Writes stream beats to word-aligned
// strided scratchpad addresses
// ##############################
`default_nettype none

module strm_sink (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         start_i,
  input  logic [strm_pkg::ADDR_W-1:0]  base_i,
  input  logic [strm_pkg::ADDR_W-1:0]  stride_i,
  input  logic [strm_pkg::CNT_W-1:0]   count_i,
  output logic                         ready_o,
  output logic                         done_o,
  output logic                         req_o,
  output strm_pkg::mem_op_e            op_o,
  output logic [strm_pkg::ADDR_W-1:0]  addr_o,
  output logic [strm_pkg::STRM_DW-1:0] wdata_o,
  input  logic                         gnt_i,
  input  logic                         snk_valid_i,
  input  logic [strm_pkg::STRM_DW-1:0] snk_data_i,
  output logic                         snk_ready_o
);

  strm_pkg::strm_state_e cs, ns;

  logic                        start_go;
  logic                        ag_valid;
  logic                        ag_take;
  logic                        ag_last;
  logic [strm_pkg::ADDR_W-1:0] ag_addr;

  assign ready_o  = (cs == strm_pkg::STRM_IDLE);
  assign start_go = start_i & ready_o;

  strm_addr_gen i_addr_gen (
    .clk_i        ( clk_i    ),
    .rst_ni       ( rst_ni   ),
    .start_i      ( start_go ),
    .base_i       ( base_i   ),
    .stride_i     ( stride_i ),
    .count_i      ( count_i  ),
    .addr_ready_i ( ag_take  ),
    .addr_valid_o ( ag_valid ),
    .addr_o       ( ag_addr  ),
    .last_o       ( ag_last  )
  );

  assign req_o       = (cs == strm_pkg::STRM_WORKING) & ag_valid & snk_valid_i;
  assign op_o        = strm_pkg::MEM_WRITE;
  assign addr_o      = {ag_addr[strm_pkg::ADDR_W-1:2], 2'b00};  // low bits ignored
  assign wdata_o     = snk_data_i;
  assign ag_take     = req_o & gnt_i;
  assign snk_ready_o = ag_take;                                 // beat and address go together

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) cs <= strm_pkg::STRM_IDLE;
    else         cs <= ns;
  end

  always_comb begin
    ns     = cs;
    done_o = 1'b0;
    case (cs)
      strm_pkg::STRM_IDLE: begin
        if (start_i) ns = strm_pkg::STRM_WORKING;
      end
      strm_pkg::STRM_WORKING: begin
        if (!ag_valid || (ag_take && ag_last)) ns = strm_pkg::STRM_DRAIN;  // last write taken
      end
      strm_pkg::STRM_DRAIN: begin
        ns     = strm_pkg::STRM_IDLE;  // writes need no response
        done_o = 1'b1;
      end
      default: ns = strm_pkg::STRM_IDLE;
    endcase
  end

  // pending beat stays put until it is written
  a_beat_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (snk_valid_i && !snk_ready_o) |=> (snk_valid_i && $stable(snk_data_i)));

endmodule

`default_nettype wire

// File: logic/mem_arbiter.sv
// ##############################
// Memory arbiter
// Round-robin between two initiators,
// routes read valid back to its owner
// ##############################
`default_nettype none

module mem_arbiter (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req0_i,
  input  strm_pkg::mem_op_e            op0_i,
  input  logic [strm_pkg::ADDR_W-1:0]  addr0_i,
  input  logic [strm_pkg::STRM_DW-1:0] wdata0_i,
  output logic                         gnt0_o,
  output logic                         r_valid0_o,
  input  logic                         req1_i,
  input  strm_pkg::mem_op_e            op1_i,
  input  logic [strm_pkg::ADDR_W-1:0]  addr1_i,
  input  logic [strm_pkg::STRM_DW-1:0] wdata1_i,
  output logic                         gnt1_o,
  output logic                         r_valid1_o,
  output logic                         mem_req_o,
  output strm_pkg::mem_op_e            mem_op_o,
  output logic [strm_pkg::ADDR_W-1:0]  mem_addr_o,
  output logic [strm_pkg::STRM_DW-1:0] mem_wdata_o,
  input  logic                         mem_gnt_i,
  input  logic                         mem_r_valid_i
);

  logic last_q;   // initiator granted last time
  logic owner_q;  // initiator of the read in flight
  logic sel;      // 1 picks initiator 1

  assign sel         = req1_i & (~req0_i | ~last_q);  // on conflict the other one wins
  assign mem_req_o   = req0_i | req1_i;
  assign mem_op_o    = sel ? op1_i    : op0_i;
  assign mem_addr_o  = sel ? addr1_i  : addr0_i;
  assign mem_wdata_o = sel ? wdata1_i : wdata0_i;
  assign gnt0_o      = req0_i & ~sel & mem_gnt_i;
  assign gnt1_o      = req1_i &  sel & mem_gnt_i;
  assign r_valid0_o  = mem_r_valid_i & ~owner_q;
  assign r_valid1_o  = mem_r_valid_i &  owner_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (mem_req_o & mem_gnt_i) begin
      last_q <= sel;
      if (mem_op_o == strm_pkg::MEM_READ) owner_q <= sel;
    end
  end

  // back-to-back conflicts alternate the winner
  a_alternate : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req0_i && req1_i && mem_gnt_i && $past(req0_i && req1_i && mem_gnt_i))
      |-> (gnt1_o != $past(gnt1_o)));

  a_read_latency : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && mem_gnt_i && mem_op_o == strm_pkg::MEM_READ) |=> mem_r_valid_i);

endmodule

`default_nettype wire

// File: logic/scratch_mem.sv
// ##############################
// Scratchpad memory
// 32-bit words, 64-bit read of two
// adjacent words, one-cycle read
// ##############################
`default_nettype none

module scratch_mem (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  strm_pkg::mem_op_e            op_i,
  input  logic [strm_pkg::ADDR_W-1:0]  addr_i,
  input  logic [strm_pkg::STRM_DW-1:0] wdata_i,
  output logic                         gnt_o,
  output logic                         r_valid_o,
  output logic [strm_pkg::MEM_DW-1:0]  r_data_o
);

  logic [strm_pkg::STRM_DW-1:0] mem [strm_pkg::MEM_WORDS];
  logic [strm_pkg::WORD_AW-1:0] idx;
  logic [strm_pkg::WORD_AW-1:0] idx_nxt;
  logic                         rd;

  assign gnt_o   = req_i;                        // always free
  assign idx     = addr_i[strm_pkg::ADDR_W-1:2];
  assign idx_nxt = idx + 1'b1;                   // wraps at top word
  assign rd      = req_i & (op_i == strm_pkg::MEM_READ);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) r_valid_o <= 1'b0;
    else         r_valid_o <= rd;
  end

  always_ff @(posedge clk_i) begin
    if (rd) r_data_o <= {mem[idx_nxt], mem[idx]};
    if (req_i && op_i == strm_pkg::MEM_WRITE) mem[idx] <= wdata_i;
  end

  // byte lane bits are not decoded
  a_word_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (addr_i[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: logic/strm_top.sv
// ##############################
// Streamer top level
// Load and store streamers sharing
// one scratchpad through an arbiter
// ##############################
`default_nettype none

module strm_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         src_start_i,
  input  logic [strm_pkg::ADDR_W-1:0]  src_base_i,
  input  logic [strm_pkg::ADDR_W-1:0]  src_stride_i,
  input  logic [strm_pkg::CNT_W-1:0]   src_count_i,
  output logic                         src_ctrl_ready_o,
  output logic                         src_done_o,
  output logic                         src_valid_o,
  output logic [strm_pkg::STRM_DW-1:0] src_data_o,
  input  logic                         src_ready_i,
  input  logic                         snk_start_i,
  input  logic [strm_pkg::ADDR_W-1:0]  snk_base_i,
  input  logic [strm_pkg::ADDR_W-1:0]  snk_stride_i,
  input  logic [strm_pkg::CNT_W-1:0]   snk_count_i,
  output logic                         snk_ctrl_ready_o,
  output logic                         snk_done_o,
  input  logic                         snk_valid_i,
  input  logic [strm_pkg::STRM_DW-1:0] snk_data_i,
  output logic                         snk_ready_o
);

  logic                         src_req, src_gnt, src_r_valid;
  strm_pkg::mem_op_e            src_op;
  logic [strm_pkg::ADDR_W-1:0]  src_addr;
  logic                         snk_req, snk_gnt;
  strm_pkg::mem_op_e            snk_op;
  logic [strm_pkg::ADDR_W-1:0]  snk_addr;
  logic [strm_pkg::STRM_DW-1:0] snk_wdata;
  logic                         mem_req, mem_gnt, mem_r_valid;
  strm_pkg::mem_op_e            mem_op;
  logic [strm_pkg::ADDR_W-1:0]  mem_addr;
  logic [strm_pkg::STRM_DW-1:0] mem_wdata;
  logic [strm_pkg::MEM_DW-1:0]  mem_r_data;

  strm_source i_source (
    .clk_i       ( clk_i            ),
    .rst_ni      ( rst_ni           ),
    .start_i     ( src_start_i      ),
    .base_i      ( src_base_i       ),
    .stride_i    ( src_stride_i     ),
    .count_i     ( src_count_i      ),
    .ready_o     ( src_ctrl_ready_o ),
    .done_o      ( src_done_o       ),
    .req_o       ( src_req          ),
    .op_o        ( src_op           ),
    .addr_o      ( src_addr         ),
    .gnt_i       ( src_gnt          ),
    .r_valid_i   ( src_r_valid      ),
    .r_data_i    ( mem_r_data       ),  // read data bypasses the arbiter
    .src_valid_o ( src_valid_o      ),
    .src_data_o  ( src_data_o       ),
    .src_ready_i ( src_ready_i      )
  );

  strm_sink i_sink (
    .clk_i       ( clk_i            ),
    .rst_ni      ( rst_ni           ),
    .start_i     ( snk_start_i      ),
    .base_i      ( snk_base_i       ),
    .stride_i    ( snk_stride_i     ),
    .count_i     ( snk_count_i      ),
    .ready_o     ( snk_ctrl_ready_o ),
    .done_o      ( snk_done_o       ),
    .req_o       ( snk_req          ),
    .op_o        ( snk_op           ),
    .addr_o      ( snk_addr         ),
    .wdata_o     ( snk_wdata        ),
    .gnt_i       ( snk_gnt          ),
    .snk_valid_i ( snk_valid_i      ),
    .snk_data_i  ( snk_data_i       ),
    .snk_ready_o ( snk_ready_o      )
  );

  mem_arbiter i_arbiter (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .req0_i        ( src_req     ),  // initiator 0 is the load side
    .op0_i         ( src_op      ),
    .addr0_i       ( src_addr    ),
    .wdata0_i      ( '0          ),
    .gnt0_o        ( src_gnt     ),
    .r_valid0_o    ( src_r_valid ),
    .req1_i        ( snk_req     ),
    .op1_i         ( snk_op      ),
    .addr1_i       ( snk_addr    ),
    .wdata1_i      ( snk_wdata   ),
    .gnt1_o        ( snk_gnt     ),
    .r_valid1_o    (             ),  // sink only writes
    .mem_req_o     ( mem_req     ),
    .mem_op_o      ( mem_op      ),
    .mem_addr_o    ( mem_addr    ),
    .mem_wdata_o   ( mem_wdata   ),
    .mem_gnt_i     ( mem_gnt     ),
    .mem_r_valid_i ( mem_r_valid )
  );

  scratch_mem i_mem (
    .clk_i     ( clk_i       ),
    .rst_ni    ( rst_ni      ),
    .req_i     ( mem_req     ),
    .op_i      ( mem_op      ),
    .addr_i    ( mem_addr    ),
    .wdata_i   ( mem_wdata   ),
    .gnt_o     ( mem_gnt     ),
    .r_valid_o ( mem_r_valid ),
    .r_data_o  ( mem_r_data  )
  );

endmodule

`default_nettype wire

// File: sim/tb_strm_top.sv
// ##############################
// Streamer top testbench
// Job table checked against a
// byte-level memory model
// ##############################
`default_nettype none

module tb_strm_top;

  timeunit 1ns;
  timeprecision 1ps;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         src_start_i;
  logic [strm_pkg::ADDR_W-1:0]  src_base_i;
  logic [strm_pkg::ADDR_W-1:0]  src_stride_i;
  logic [strm_pkg::CNT_W-1:0]   src_count_i;
  logic                         src_ctrl_ready_o;
  logic                         src_done_o;
  logic                         src_valid_o;
  logic [strm_pkg::STRM_DW-1:0] src_data_o;
  logic                         src_ready_i;
  logic                         snk_start_i;
  logic [strm_pkg::ADDR_W-1:0]  snk_base_i;
  logic [strm_pkg::ADDR_W-1:0]  snk_stride_i;
  logic [strm_pkg::CNT_W-1:0]   snk_count_i;
  logic                         snk_ctrl_ready_o;
  logic                         snk_done_o;
  logic                         snk_valid_i;
  logic [strm_pkg::STRM_DW-1:0] snk_data_i;
  logic                         snk_ready_o;

  // job table, one entry per row in every queue
  string job_name[$];
  int    job_snk_base[$];
  int    job_snk_stride[$];
  int    job_snk_count[$];
  int    job_src_base[$];
  int    job_src_stride[$];
  int    job_src_count[$];
  bit    job_both[$];
  bit    job_stall[$];

  logic [7:0]  model [strm_pkg::MEM_WORDS*4];  // byte image of the scratchpad
  integer      seed;
  int          cur = 0;                        // running job
  int          cycles = 0;
  int          cycle_limit = 100;
  int          snk_got;                        // sink beats taken
  int          src_got;                        // source beats taken
  bit          snk_busy;
  bit          src_busy;
  bit          snk_shown;                      // sink beat on the bus
  bit          snk_taken;
  bit          src_hold;                       // source beat stalled last cycle
  logic [31:0] src_held;

  strm_top dut (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .src_start_i      ( src_start_i      ),
    .src_base_i       ( src_base_i       ),
    .src_stride_i     ( src_stride_i     ),
    .src_count_i      ( src_count_i      ),
    .src_ctrl_ready_o ( src_ctrl_ready_o ),
    .src_done_o       ( src_done_o       ),
    .src_valid_o      ( src_valid_o      ),
    .src_data_o       ( src_data_o       ),
    .src_ready_i      ( src_ready_i      ),
    .snk_start_i      ( snk_start_i      ),
    .snk_base_i       ( snk_base_i       ),
    .snk_stride_i     ( snk_stride_i     ),
    .snk_count_i      ( snk_count_i      ),
    .snk_ctrl_ready_o ( snk_ctrl_ready_o ),
    .snk_done_o       ( snk_done_o       ),
    .snk_valid_i      ( snk_valid_i      ),
    .snk_data_i       ( snk_data_i       ),
    .snk_ready_o      ( snk_ready_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    assert (cycles <= cycle_limit)
      else report_failure($sformatf("timeout, jobs still running after %0d cycles", cycles));
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp)
      else report_failure($sformatf("ERROR %s %s: expected %h, actual %h",
                                    job_name[cur], what, exp, act));
  endtask

  task automatic add_job(input string name, input int sb, input int ss, input int sc,
                         input int rb, input int rs, input int rc, input bit both,
                         input bit stall);
    job_name.push_back(name);
    job_snk_base.push_back(sb);
    job_snk_stride.push_back(ss);
    job_snk_count.push_back(sc);
    job_src_base.push_back(rb);
    job_src_stride.push_back(rs);
    job_src_count.push_back(rc);
    job_both.push_back(both);
    job_stall.push_back(stall);
  endtask

  // four bytes from the k-th source address, little-endian, wrapping
  function automatic logic [31:0] expected_src_word(input int k);
    int          a;
    logic [31:0] w;
    a = (job_src_base[cur] + k * job_src_stride[cur]) % (strm_pkg::MEM_WORDS * 4);
    for (int i = 0; i < 4; i++) begin
      w[8*i +: 8] = model[(a + i) % (strm_pkg::MEM_WORDS * 4)];
    end
    return w;
  endfunction

  task automatic write_model(input int k, input logic [31:0] data);
    int a;
    a = (job_snk_base[cur] + k * job_snk_stride[cur]) % (strm_pkg::MEM_WORDS * 4);
    a = a & ~3;  // sink writes whole words
    for (int i = 0; i < 4; i++) begin
      model[a + i] = data[8*i +: 8];
    end
  endtask

  // called right after a rising edge
  task automatic drive_streams();
    bit snk_gap;
    bit src_drop;
    snk_gap  = job_stall[cur] && (($random(seed) & 1) == 0);
    src_drop = job_stall[cur] && (($random(seed) & 1) == 0);
    if (!snk_shown || snk_taken) begin  // valid may only drop after a transfer
      if (snk_busy && snk_got < job_snk_count[cur] && !snk_gap) begin
        snk_valid_i <= 1'b1;
        snk_data_i  <= $random(seed);
        snk_shown = 1'b1;
      end else begin
        snk_valid_i <= 1'b0;
        snk_shown = 1'b0;
      end
    end
    src_ready_i <= !src_drop;
  endtask

  // called at the falling edge, where all outputs are settled
  task automatic sample_outputs();
    if (src_hold) begin
      assert (src_valid_o) else report_failure("source valid dropped before its beat transferred");
      check_value("held source beat", src_held, src_data_o);
    end
    assert (!src_valid_o || src_busy) else report_failure("source valid while no load job runs");
    if (src_valid_o && src_ready_i) begin
      assert (src_got < job_src_count[cur]) else report_failure("source sent more beats than count");
      check_value($sformatf("source beat %0d", src_got), expected_src_word(src_got), src_data_o);
      src_got++;
    end
    src_hold = src_valid_o && !src_ready_i;
    src_held = src_data_o;
    snk_taken = snk_valid_i && snk_ready_o;
    if (snk_taken) begin
      write_model(snk_got, snk_data_i);
      snk_got++;
    end
    if (snk_done_o) begin
      assert (snk_busy) else report_failure("sink done pulse with no store job running");
      check_value("sink beats at done", job_snk_count[cur], snk_got);
      snk_busy = 1'b0;
    end
    if (src_done_o) begin
      assert (src_busy) else report_failure("source done pulse with no load job running");
      check_value("source beats at done", job_src_count[cur], src_got);
      src_busy = 1'b0;
    end
  endtask

  task automatic run_engines(input bit use_snk, input bit use_src);
    assert (snk_ctrl_ready_o && src_ctrl_ready_o)
      else report_failure("an engine is not ready before its start");
    snk_busy  = use_snk;
    src_busy  = use_src;
    snk_got   = 0;
    src_got   = 0;
    snk_shown = 1'b0;
    snk_taken = 1'b0;
    src_hold  = 1'b0;
    @(posedge clk_i);
    snk_start_i  <= use_snk;
    snk_base_i   <= strm_pkg::ADDR_W'(job_snk_base[cur]);
    snk_stride_i <= strm_pkg::ADDR_W'(job_snk_stride[cur]);
    snk_count_i  <= strm_pkg::CNT_W'(job_snk_count[cur]);
    src_start_i  <= use_src;
    src_base_i   <= strm_pkg::ADDR_W'(job_src_base[cur]);
    src_stride_i <= strm_pkg::ADDR_W'(job_src_stride[cur]);
    src_count_i  <= strm_pkg::CNT_W'(job_src_count[cur]);
    drive_streams();
    while (snk_busy || src_busy) begin
      @(negedge clk_i);
      sample_outputs();
      @(posedge clk_i);
      snk_start_i <= 1'b0;
      src_start_i <= 1'b0;
      drive_streams();
    end
    @(negedge clk_i);
    sample_outputs();  // a second done pulse fails here
    assert (snk_ctrl_ready_o && src_ctrl_ready_o)
      else report_failure("an engine is not ready again after its done pulse");
  endtask

  initial begin
    int total;
    seed = 32'ha9aa;
    // name, sink base/stride/count, source base/stride/count, together, stalls
    add_job("aligned_round_trip",   0,   4, 128, 0,    4, 128, 1'b0, 1'b0);
    add_job("fill_upper_half",      512, 4, 128, 512,  4, 32,  1'b0, 1'b0);
    add_job("misaligned_ofs1_s5",   0,   0, 0,   1,    5, 40,  1'b0, 1'b0);
    add_job("misaligned_ofs2_s7",   0,   0, 0,   2,    7, 40,  1'b0, 1'b0);
    add_job("misaligned_ofs3_wrap", 0,   0, 0,   1019, 7, 30,  1'b0, 1'b0);
    add_job("backpressure_trip",    256, 4, 64,  256,  4, 64,  1'b0, 1'b1);
    add_job("backpressure_misalig", 0,   0, 0,   301,  5, 40,  1'b0, 1'b1);
    add_job("shared_port",          700, 8, 40,  3,    5, 40,  1'b1, 1'b0);
    add_job("shared_port_stalls",   100, 4, 50,  600,  7, 50,  1'b1, 1'b1);
    total = 0;
    foreach (job_name[j]) total += job_snk_count[j] + job_src_count[j];
    cycle_limit = 20 * total + 100;

    rst_ni       <= 1'b0;
    src_start_i  <= 1'b0;
    src_base_i   <= '0;
    src_stride_i <= '0;
    src_count_i  <= '0;
    src_ready_i  <= 1'b0;
    snk_start_i  <= 1'b0;
    snk_base_i   <= '0;
    snk_stride_i <= '0;
    snk_count_i  <= '0;
    snk_valid_i  <= 1'b0;
    snk_data_i   <= '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (src_ctrl_ready_o && snk_ctrl_ready_o) else report_failure("engines not ready after reset");
    assert (!src_done_o && !snk_done_o && !src_valid_o && !snk_ready_o)
      else report_failure("stream or done outputs active after reset");

    for (int j = 0; j < job_name.size(); j++) begin
      cur = j;
      if (job_both[j]) begin
        run_engines(job_snk_count[j] != 0, job_src_count[j] != 0);
      end else begin
        if (job_snk_count[j] != 0) run_engines(1'b1, 1'b0);  // store first
        if (job_src_count[j] != 0) run_engines(1'b0, 1'b1);
      end
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
logic/strm_pkg.sv
logic/strm_addr_gen.sv
logic/strm_source.sv
logic/strm_sink.sv
logic/mem_arbiter.sv
logic/scratch_mem.sv
logic/strm_top.sv
sim/tb_strm_top.sv

// File: Makefile
# Verilator flow for the streamer project

VERILATOR   ?= verilator
TOP         ?= tb_strm_top
FILELIST    ?= sources.f
BUILD_DIR   ?= obj_dir
LINT_FLAGS  ?= --lint-only -Wall
SIM_FLAGS   ?= --binary --timing --assert -Wno-fatal
EXTRA_FLAGS ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard logic/*.sv) $(wildcard sim/*.sv)
	$(VERILATOR) $(SIM_FLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# a $fatal in the testbench gives a non-zero exit status
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
